/* compile.f */
+incdir+include
rtl/lpif_pkg.sv
rtl/ll_auto_sync.sv
rtl/lpif_tx_concat.sv
rtl/lpif_rx_concat.sv
rtl/lpif_link_top.sv
bench/tb_lpif_link.sv

/* run.sh */
#!/bin/sh
# Build and run the LPIF link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f compile.f --top-module tb_lpif_link \
  -Mdir obj_dir -o tb_lpif_link

out=$(./obj_dir/tb_lpif_link)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

/* include/lpif_bench_vectors.svh */
// Loopback vector table for the LPIF link testbench
// Fixed columns of each stimulus row and the full entry
// struct with expected values

`ifndef LPIF_BENCH_VECTORS_SVH
`define LPIF_BENCH_VECTORS_SVH

// Fixed part of one row, data and crc come from $random
typedef struct packed {
  lpif_state_e state;
  logic [1:0]  protid;
  logic        dvalid;
  logic        crc_valid;
  logic        valid;
  logic        corrupt;
} row_t;

// Full entry, one per cycle
typedef struct packed {
  lpif_flit_t  flit;
  logic        corrupt;
  lpif_flit_t  exp_ustrm;
  logic [15:0] exp_misalign;
} vec_entry_t;

localparam int NUM_VEC = 10;

// Columns: state, protid, dvalid, crc_valid, valid, corrupt
localparam row_t ROWS [NUM_VEC] = '{
  '{lpif_active,  2'd0, 1'b1, 1'b1, 1'b1, 1'b0},
  '{lpif_active,  2'd1, 1'b1, 1'b0, 1'b1, 1'b0},
  '{lpif_retrain, 2'd2, 1'b0, 1'b1, 1'b1, 1'b0},
  // Idle cycle, still carried by the strobe
  '{lpif_active,  2'd3, 1'b1, 1'b1, 1'b0, 1'b0},
  '{lpif_active,  2'd0, 1'b1, 1'b1, 1'b1, 1'b1},
  // Good entry right after a corrupt one
  '{lpif_l1,      2'd1, 1'b1, 1'b1, 1'b1, 1'b0},
  '{lpif_l2,      2'd2, 1'b1, 1'b0, 1'b1, 1'b0},
  '{lpif_active,  2'd0, 1'b0, 1'b0, 1'b0, 1'b0},
  '{lpif_reset,   2'd3, 1'b1, 1'b1, 1'b1, 1'b1},
  '{lpif_active,  2'd1, 1'b1, 1'b1, 1'b1, 1'b0}
};

`endif

/* bench/tb_lpif_link.sv */
// Loopback testbench for the LPIF link top
// Clock and reset, online bring-up, table-driven loopback
// with channel corruption, status checks and final report

module tb_lpif_link;

  import lpif_pkg::*;

  `include "lpif_bench_vectors.svh"

  localparam int DELAY_W        = 16;
  localparam int ONLINE_TIMEOUT = 50;
  localparam int DROP_TIMEOUT   = 10;

  logic               clk_wr;
  logic               rst_n;
  logic               tx_online;
  logic               rx_online;
  logic [DELAY_W-1:0] delay_x_value;
  logic [DELAY_W-1:0] delay_y_value;
  logic               tx_mrk_userbit;
  logic               tx_stb_userbit;
  lpif_flit_t         dstrm;
  lpif_flit_t         ustrm;
  phy_word_t          tx_phy0;
  phy_word_t          tx_phy1;
  phy_word_t          rx_phy0;
  phy_word_t          rx_phy1;
  link_status_t       tx_status;
  link_status_t       rx_status;

  // Corrupt flag of the entry now on the tx words
  logic               corrupt_on_phy;
  vec_entry_t         vectors [NUM_VEC];
  integer             seed;
  int                 errors;
  int                 timeouts;

  lpif_link_top #(
    .DELAY_W (DELAY_W)
  ) lpif_link_top_i (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .tx_mrk_userbit             (tx_mrk_userbit),
    .tx_stb_userbit             (tx_stb_userbit),
    .dstrm                      (dstrm),
    .ustrm                      (ustrm),
    .tx_phy0                    (tx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy0                    (rx_phy0),
    .rx_phy1                    (rx_phy1),
    .tx_downstream_debug_status (tx_status),
    .rx_upstream_debug_status   (rx_status)
  );

  ////////////////////////////////////////
  // Clock and PHY return path

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  // Straight loopback with the channel 1 strobe flipped on corrupt entries
  always_comb begin
    rx_phy0        = tx_phy0;
    rx_phy1        = tx_phy1;
    rx_phy1.strobe = tx_phy1.strobe ^ corrupt_on_phy;
  end

  ////////////////////////////////////////
  // Helpers

  task automatic report_mismatch(input string name, input logic [95:0] got,
                                 input logic [95:0] exp);
    errors++;
    $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
  endtask

  // Channel word for one flit, low or high half of the padded flit
  function automatic phy_word_t expected_phy_word(input lpif_flit_t flit,
                                                  input logic upper);
    logic [2*PHY_PAYLOAD_W-1:0] padded;
    phy_word_t                  w;
    padded                  = '0;
    padded[LPIF_FLIT_W-1:0] = flit;
    w.marker                = tx_mrk_userbit;
    w.strobe                = tx_stb_userbit;
    if (upper) begin
      w.payload = padded[2*PHY_PAYLOAD_W-1:PHY_PAYLOAD_W];
    end else begin
      w.payload = padded[PHY_PAYLOAD_W-1:0];
    end
    return w;
  endfunction

  // Random data and crc with expected values from the loopback rule
  function automatic void build_vectors();
    logic [31:0] rnd;
    logic [15:0] bad_cnt;
    bad_cnt = '0;
    for (int i = 0; i < NUM_VEC; i++) begin
      rnd                        = $random(seed);
      vectors[i].flit.state      = ROWS[i].state;
      vectors[i].flit.protid     = ROWS[i].protid;
      vectors[i].flit.data       = {$random(seed), $random(seed)};
      vectors[i].flit.dvalid     = ROWS[i].dvalid;
      vectors[i].flit.crc        = rnd[15:0];
      vectors[i].flit.crc_valid  = ROWS[i].crc_valid;
      vectors[i].flit.valid      = ROWS[i].valid;
      vectors[i].corrupt         = ROWS[i].corrupt;
      // Broken pair gives an empty flit
      if (ROWS[i].corrupt) begin
        bad_cnt                = bad_cnt + 16'd1;
        vectors[i].exp_ustrm   = '0;
      end else begin
        vectors[i].exp_ustrm   = vectors[i].flit;
      end
      vectors[i].exp_misalign = bad_cnt;
    end
  endfunction

  ////////////////////////////////////////
  // Main sequence

  initial begin
    int        tx_cycle;
    int        rx_cycle;
    int        n_valid;
    int        k;
    logic      done;
    phy_word_t exp_word;
    seed     = 54959;
    errors   = 0;
    timeouts = 0;
    rst_n          <= 1'b0;
    tx_online      <= 1'b0;
    rx_online      <= 1'b0;
    delay_x_value  <= DELAY_W'(3);
    delay_y_value  <= DELAY_W'(2);
    tx_mrk_userbit <= 1'b1;
    tx_stb_userbit <= 1'b1;
    dstrm          <= '0;
    corrupt_on_phy <= 1'b0;
    build_vectors();
    repeat (2) @(posedge clk_wr);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk_wr);

    // Link still down so everything is quiet
    @(negedge clk_wr);
    if (tx_phy0 !== '0) report_mismatch("tx_phy0", 96'(tx_phy0), '0);
    if (tx_phy1 !== '0) report_mismatch("tx_phy1", 96'(tx_phy1), '0);
    if (ustrm !== '0) report_mismatch("ustrm", 96'(ustrm), '0);
    // Online bits and counters all clear
    if (tx_status !== '0) report_mismatch("tx_status", 96'(tx_status), '0);
    if (rx_status !== '0) report_mismatch("rx_status", 96'(rx_status), '0);

    // Bring-up where the tx bit must come first
    @(posedge clk_wr);
    tx_online <= 1'b1;
    rx_online <= 1'b1;
    tx_cycle = -1;
    rx_cycle = -1;
    for (int c = 0; c < ONLINE_TIMEOUT && rx_cycle < 0; c++) begin
      @(negedge clk_wr);
      if (tx_cycle < 0 && tx_status.tx_online) tx_cycle = c;
      if (rx_cycle < 0 && tx_status.rx_online) rx_cycle = c;
    end
    if (tx_cycle < 0 || rx_cycle < 0) begin
      timeouts++;
      $display("Timeout waiting for both online bits in the tx status word");
    end else if (tx_cycle >= rx_cycle) begin
      errors++;
      $display("rx online bit came up no later than tx online bit");
    end
    // Same online levels in the rx status word
    if (rx_status.tx_online !== 1'b1) begin
      report_mismatch("rx_status.tx_online", 96'(rx_status.tx_online), 96'(1'b1));
    end
    if (rx_status.rx_online !== 1'b1) begin
      report_mismatch("rx_status.rx_online", 96'(rx_status.rx_online), 96'(1'b1));
    end

    // Table loop with entry c-1 on the tx words and entry c-2 due on ustrm
    for (int c = 0; c < NUM_VEC + 2; c++) begin
      @(posedge clk_wr);
      if (c < NUM_VEC) dstrm <= vectors[c].flit;
      else dstrm <= '0;
      if (c >= 1 && c <= NUM_VEC) corrupt_on_phy <= vectors[c-1].corrupt;
      else corrupt_on_phy <= 1'b0;
      @(negedge clk_wr);
      if (c >= 1 && c <= NUM_VEC) begin
        exp_word = expected_phy_word(vectors[c-1].flit, 1'b0);
        if (tx_phy0 !== exp_word) begin
          report_mismatch("tx_phy0", 96'(tx_phy0), 96'(exp_word));
        end
        exp_word = expected_phy_word(vectors[c-1].flit, 1'b1);
        if (tx_phy1 !== exp_word) begin
          report_mismatch("tx_phy1", 96'(tx_phy1), 96'(exp_word));
        end
      end
      if (c >= 2) begin
        k = c - 2;
        if (ustrm !== vectors[k].exp_ustrm) begin
          report_mismatch("ustrm", 96'(ustrm), 96'(vectors[k].exp_ustrm));
        end
        if (rx_status.count !== vectors[k].exp_misalign) begin
          report_mismatch("rx_misalign_count", 96'(rx_status.count),
                          96'(vectors[k].exp_misalign));
        end
      end
    end

    // Sent flits, every entry applied while online
    n_valid = 0;
    for (int i = 0; i < NUM_VEC; i++) begin
      if (vectors[i].flit.valid) n_valid++;
    end
    if (tx_status.count !== 16'(n_valid)) begin
      report_mismatch("tx_flit_count", 96'(tx_status.count), 96'(16'(n_valid)));
    end

    // Link drop with a live flit held on dstrm
    @(posedge clk_wr);
    tx_online <= 1'b0;
    dstrm     <= vectors[0].flit;
    done = 1'b0;
    for (int c = 0; c < DROP_TIMEOUT && !done; c++) begin
      @(negedge clk_wr);
      done = !tx_status.tx_online && !tx_status.rx_online &&
             !rx_status.tx_online && !rx_status.rx_online;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout waiting for both online bits to clear after tx_online drop");
    end
    done = 1'b0;
    for (int c = 0; c < DROP_TIMEOUT && !done; c++) begin
      @(negedge clk_wr);
      done = (tx_phy0 === '0) && (tx_phy1 === '0) && (ustrm === '0);
    end
    if (!done) begin
      timeouts++;
      $display("Timeout waiting for PHY words and ustrm to return to zero");
    end

    $display("Error count: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* rtl/lpif_link_top.sv */
// LPIF over AIB logic link top, master side
// Auto sync, transmit concat and receive concat,
// no FIFO and no credit logic

module lpif_link_top #(
  parameter int DELAY_W = 16
) (
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Raw online levels
  input  logic                   tx_online,
  input  logic                   rx_online,

  // Online delay counts
  input  logic [DELAY_W-1:0]     delay_x_value,
  input  logic [DELAY_W-1:0]     delay_y_value,

  // User strobe and marker levels
  input  logic                   tx_mrk_userbit,
  input  logic                   tx_stb_userbit,

  // LPIF user side
  input  lpif_pkg::lpif_flit_t   dstrm,
  output lpif_pkg::lpif_flit_t   ustrm,

  // PHY side
  output lpif_pkg::phy_word_t    tx_phy0,
  output lpif_pkg::phy_word_t    tx_phy1,
  input  lpif_pkg::phy_word_t    rx_phy0,
  input  lpif_pkg::phy_word_t    rx_phy1,

  // Debug status
  output lpif_pkg::link_status_t tx_downstream_debug_status,
  output lpif_pkg::link_status_t rx_upstream_debug_status
);

  // Delayed online levels and gated user bits
  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_auto_stb_userbit;
  logic tx_auto_mrk_userbit;

  ////////////////////////////////////////
  // Auto sync

  ll_auto_sync #(
    .DELAY_W (DELAY_W)
  ) ll_auto_sync_i (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  ////////////////////////////////////////
  // Transmit path

  // Downstream flit onto both channels
  lpif_tx_concat lpif_tx_concat_i (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .dstrm          (dstrm),
    .tx_online      (tx_online_delay),
    .rx_online      (rx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit),
    .tx_mrk_userbit (tx_auto_mrk_userbit),
    .tx_phy0        (tx_phy0),
    .tx_phy1        (tx_phy1),
    .status         (tx_downstream_debug_status)
  );

  ////////////////////////////////////////
  // Receive path

  // Both channels back into an upstream flit
  lpif_rx_concat lpif_rx_concat_i (
    .clk_wr    (clk_wr),
    .rst_n     (rst_n),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .rx_online (rx_online_delay),
    .tx_online (tx_online_delay),
    .ustrm     (ustrm),
    .status    (rx_upstream_debug_status)
  );

endmodule

/* rtl/lpif_rx_concat.sv */
// Receive concat
// Strobe and marker alignment check across both channels,
// upstream flit unpack and register, misalignment counter

module lpif_rx_concat (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Channel words from the PHY
  input  lpif_pkg::phy_word_t   rx_phy0,
  input  lpif_pkg::phy_word_t   rx_phy1,

  // Delayed online levels
  input  logic                  rx_online,
  input  logic                  tx_online,

  output lpif_pkg::lpif_flit_t  ustrm,
  output lpif_pkg::link_status_t status
);

  import lpif_pkg::*;

  logic                    stb_both;
  logic                    stb_diff;
  logic                    mrk_diff;
  logic                    accept;
  logic                    misalign;
  lpif_flit_t              flit_d;
  logic [STATUS_CNT_W-1:0] misalign_cnt_q;

  ////////////////////////////////////////
  // Alignment check

  assign stb_both = rx_phy0.strobe & rx_phy1.strobe;
  assign stb_diff = rx_phy0.strobe ^ rx_phy1.strobe;
  assign mrk_diff = rx_phy0.marker ^ rx_phy1.marker;

  // Both strobes set and markers agree
  assign accept   = rx_online & stb_both & ~mrk_diff;

  // Channels out of step while online
  assign misalign = rx_online & (stb_diff | mrk_diff);

  ////////////////////////////////////////
  // Unpack

  // Pad bits of channel 1 are dropped
  assign flit_d = lpif_flit_t'({rx_phy1.payload[PHY1_FLIT_W-1:0], rx_phy0.payload});

  // One cycle from the PHY pins to ustrm
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm <= '0;
    end else if (accept) begin
      ustrm <= flit_d;
    end else begin
      // Rejected or idle pair gives an empty flit
      ustrm <= '0;
    end
  end

  ////////////////////////////////////////
  // Misalignment count

  // Wraps at 16 bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      misalign_cnt_q <= '0;
    end else if (misalign) begin
      misalign_cnt_q <= misalign_cnt_q + 1'b1;
    end
  end

  // Status word
  always_comb begin
    status.count     = misalign_cnt_q;
    status.tx_online = tx_online;
    status.rx_online = rx_online;
    status.reserved  = '0;
  end

endmodule

/* rtl/lpif_tx_concat.sv */
// Transmit concat
// Packs a downstream flit into two registered PHY words,
// sent flit counter and tx status word

module lpif_tx_concat (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Downstream flit, valid is a per-cycle strobe
  input  lpif_pkg::lpif_flit_t  dstrm,

  // Delayed online levels
  input  logic                  tx_online,
  input  logic                  rx_online,

  // Gated strobe and marker
  input  logic                  tx_stb_userbit,
  input  logic                  tx_mrk_userbit,

  output lpif_pkg::phy_word_t   tx_phy0,
  output lpif_pkg::phy_word_t   tx_phy1,
  output lpif_pkg::link_status_t status
);

  import lpif_pkg::*;

  // Flit padded out to both payloads
  logic [2*PHY_PAYLOAD_W-1:0] flit_ext;
  phy_word_t                  phy0_d;
  phy_word_t                  phy1_d;
  logic [STATUS_CNT_W-1:0]    flit_cnt_q;

  ////////////////////////////////////////
  // Packing

  // Top pad bits are zero
  assign flit_ext = {{(2*PHY_PAYLOAD_W-LPIF_FLIT_W){1'b0}}, dstrm};

  always_comb begin
    // Low half on channel 0
    phy0_d.marker  = tx_mrk_userbit;
    phy0_d.strobe  = tx_stb_userbit;
    phy0_d.payload = flit_ext[PHY_PAYLOAD_W-1:0];
    // High half on channel 1, same strobe and marker
    phy1_d.marker  = tx_mrk_userbit;
    phy1_d.strobe  = tx_stb_userbit;
    phy1_d.payload = flit_ext[2*PHY_PAYLOAD_W-1:PHY_PAYLOAD_W];
  end

  // One cycle from dstrm to the PHY pins
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else if (tx_online) begin
      tx_phy0 <= phy0_d;
      tx_phy1 <= phy1_d;
    end else begin
      // Quiet channel while offline
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end
  end

  ////////////////////////////////////////
  // Sent flit count

  // Wraps at 16 bits
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      flit_cnt_q <= '0;
    end else if (dstrm.valid && tx_online) begin
      flit_cnt_q <= flit_cnt_q + 1'b1;
    end
  end

  // Status word
  always_comb begin
    status.count     = flit_cnt_q;
    status.tx_online = tx_online;
    status.rx_online = rx_online;
    status.reserved  = '0;
  end

endmodule

/* rtl/ll_auto_sync.sv */
// Link auto sync
// Delayed tx/rx online levels from programmable counts,
// user strobe and marker gating

module ll_auto_sync #(
  parameter int DELAY_W = 16
) (
  input  logic               clk_wr,
  input  logic               rst_n,

  // Raw online levels
  input  logic               tx_online,
  input  logic               rx_online,

  // Consecutive edge counts
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,

  // User strobe and marker levels
  input  logic               tx_mrk_userbit,
  input  logic               tx_stb_userbit,

  output logic               tx_online_delay,
  output logic               rx_online_delay,
  output logic               tx_auto_stb_userbit,
  output logic               tx_auto_mrk_userbit
);

  typedef enum logic [1:0] {
    sync_idle,
    sync_counting,
    sync_online
  } sync_state_e;

  // Index 0 is the tx direction, index 1 the rx direction
  logic               qual [2];
  logic [DELAY_W-1:0] delay_val [2];
  logic [1:0]         online;

  // rx only qualifies once tx is up
  assign qual[0] = tx_online;
  assign qual[1] = rx_online & tx_online_delay;

  assign delay_val[0] = delay_x_value;
  assign delay_val[1] = delay_y_value;

  ////////////////////////////////////////
  // Online delay FSMs

  for (genvar i = 0; i < 2; i++) begin : g_dir
    sync_state_e        state_q;
    sync_state_e        state_d;
    logic [DELAY_W-1:0] cnt_q;
    logic [DELAY_W-1:0] cnt_d;
    logic [DELAY_W:0]   cnt_inc;
    logic               cnt_done;

    // Count of qualifying edges including this one
    assign cnt_inc  = {1'b0, cnt_q} + {{DELAY_W{1'b0}}, 1'b1};
    // Zero delay is done on the first edge too
    assign cnt_done = cnt_inc >= {1'b0, delay_val[i]};

    always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
        sync_idle, sync_counting: begin
          if (!qual[i]) begin
            // Run broken, start over
            state_d = sync_idle;
            cnt_d   = '0;
          end else if (cnt_done) begin
            state_d = sync_online;
            cnt_d   = '0;
          end else begin
            state_d = sync_counting;
            cnt_d   = cnt_inc[DELAY_W-1:0];
          end
        end
        sync_online: begin
          // Drop on the first low sample
          if (!qual[i]) begin
            state_d = sync_idle;
          end
        end
        default: begin
          state_d = sync_idle;
          cnt_d   = '0;
        end
      endcase
    end

    always_ff @(posedge clk_wr or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= sync_idle;
        cnt_q   <= '0;
      end else begin
        state_q <= state_d;
        cnt_q   <= cnt_d;
      end
    end

    assign online[i] = (state_q == sync_online);
  end

  assign tx_online_delay = online[0];
  assign rx_online_delay = online[1];

  ////////////////////////////////////////
  // Strobe and marker gating

  // No strobe or marker toward the far side before tx is up
  assign tx_auto_stb_userbit = tx_stb_userbit & tx_online_delay;
  assign tx_auto_mrk_userbit = tx_mrk_userbit & tx_online_delay;

endmodule

/* rtl/lpif_pkg.sv */
// Shared LPIF link definitions
// Width constants, LPIF state codes, flit struct,
// PHY channel word struct and debug status word

package lpif_pkg;

  ////////////////////////////////////////
  // Widths

  // Flit data and CRC fields
  localparam int LPIF_DATA_W = 64;
  localparam int LPIF_CRC_W  = 16;

  // One PHY channel word, marker and strobe on top
  localparam int PHY_W         = 48;
  localparam int PHY_PAYLOAD_W = PHY_W - 2;

  // Debug counter width in the status word
  localparam int STATUS_CNT_W = 16;

  ////////////////////////////////////////
  // LPIF link state codes

  // Same codes as dstrm_state / ustrm_state
  typedef enum logic [3:0] {
    lpif_reset   = 4'h0,
    lpif_active  = 4'h1,
    lpif_l1      = 4'h4,
    lpif_l2      = 4'h8,
    lpif_retrain = 4'hb
  } lpif_state_e;

  ////////////////////////////////////////
  // Transfer structs

  // One LPIF transfer, state in the top bits
  typedef struct packed {
    lpif_state_e            state;
    logic [1:0]             protid;
    logic [LPIF_DATA_W-1:0] data;
    logic                   dvalid;
    logic [LPIF_CRC_W-1:0]  crc;
    logic                   crc_valid;
    logic                   valid;
  } lpif_flit_t;

  // Flit width, 89 bits
  localparam int LPIF_FLIT_W = $bits(lpif_flit_t);

  // Flit bits carried by the upper channel word
  localparam int PHY1_FLIT_W = LPIF_FLIT_W - PHY_PAYLOAD_W;

  // Channel word, marker bit 47 and strobe bit 46
  typedef struct packed {
    logic                     marker;
    logic                     strobe;
    logic [PHY_PAYLOAD_W-1:0] payload;
  } phy_word_t;

  // Debug status word, 32 bits
  typedef struct packed {
    logic [STATUS_CNT_W-1:0] count;
    logic                    tx_online;
    logic                    rx_online;
    logic [13:0]             reserved;
  } link_status_t;

endpackage
